/* hdl/attn_pkg.sv */
package attn_pkg;

    //////////////////////////////
    // sizes and constants
    //////////////////////////////
    localparam int N_KEY   = 4;    // keys per tile
    localparam int D_VAL   = 4;    // value columns
    localparam int SCORE_W = 8;
    localparam int VAL_W   = 8;
    localparam int ACC_W   = 24;
    localparam int SUM_W   = 16;
    localparam int WGT_W   = 9;
    localparam int W_ONE   = 256;  // weight at zero gap
    localparam int W_SHIFT = 8;    // fraction bits of a weight
    localparam int GAP_MAX = 8;    // last gap with a nonzero weight

    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic signed [VAL_W-1:0]   val_t;
    typedef logic signed [ACC_W-1:0]   acc_t;
    typedef logic        [SUM_W-1:0]   sum_t;
    typedef logic        [WGT_W-1:0]   weight_t;

    //////////////////////////////
    // handshake payloads
    //////////////////////////////
    typedef struct packed {
        score_t [N_KEY-1:0]             scores;
        val_t   [N_KEY-1:0][D_VAL-1:0]  values;
        score_t                         m_old;
        sum_t                           l_old;
        acc_t   [D_VAL-1:0]             o_old;
        score_t                         m_new;   // filled in by the max search
    } row_job_t;

    typedef struct packed {
        acc_t [D_VAL-1:0] pv;     // sum of w * v, fraction removed
        sum_t             l_pv;   // sum of the new weights
    } pv_result_t;

    typedef struct packed {
        acc_t [D_VAL-1:0] o_scaled;
        sum_t             l_scaled;
        score_t           m_new;  // job copy, passed on to the merge
    } hist_result_t;

    typedef struct packed {
        score_t           m_new;
        sum_t             l_new;
        acc_t [D_VAL-1:0] o_new;
    } row_out_t;

    // base-2 exponent weight of a non-negative gap
    function automatic weight_t exp_weight(input logic [SCORE_W:0] gap);
        weight_t w;
        if (gap > GAP_MAX) w = '0;
        else w = weight_t'(W_ONE >> gap);
        return w;
    endfunction

endpackage

/* hdl/req_ack_if.sv */
`timescale 1ns/1ps

// four-phase req/ack link, payload held stable while req is high
interface req_ack_if #(
    parameter type payload_t = logic
) ();

    logic     req;
    logic     ack;
    payload_t payload;

    modport initiator (
        output req,
        output payload,
        input  ack
    );

    modport responder (
        input  req,
        input  payload,
        output ack
    );

endinterface

/* hdl/attn_row_ctrl.sv */
`timescale 1ns/1ps

module attn_row_ctrl (
    input  logic                                                   I_CLK,
    input  logic                                                   I_ASYN_RSTN,
    input  logic                                                   i_req,
    output logic                                                   o_ack,
    input  attn_pkg::score_t [attn_pkg::N_KEY-1:0]                 i_scores,
    input  attn_pkg::val_t   [attn_pkg::N_KEY-1:0][attn_pkg::D_VAL-1:0] i_values,
    input  attn_pkg::score_t                                       i_m_old,
    input  attn_pkg::sum_t                                         i_l_old,
    input  attn_pkg::acc_t   [attn_pkg::D_VAL-1:0]                 i_o_old,
    output attn_pkg::row_out_t                                     o_out,
    req_ack_if.initiator                                           job_pv,
    req_ack_if.initiator                                           job_hist,
    req_ack_if.responder                                           res_out
);
    import attn_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_max,
        st_dispatch,
        st_wait,
        st_reply
    } state_t;

    state_t   state;
    row_job_t job_q;     // one job copy feeds both units
    score_t   m_search;

    // largest of old max and all captured scores
    always_comb begin
        m_search = job_q.m_old;
        for (int k = 0; k < N_KEY; k++) begin
            if (job_q.scores[k] > m_search) m_search = job_q.scores[k];
        end
    end

    assign job_pv.payload   = job_q;
    assign job_hist.payload = job_q;

    //////////////////////////////
    // payload registers
    //////////////////////////////
    always_ff @(posedge I_CLK) begin
        if (state == st_idle && i_req) begin
            job_q.scores <= i_scores;
            job_q.values <= i_values;
            job_q.m_old  <= i_m_old;
            job_q.l_old  <= i_l_old;
            job_q.o_old  <= i_o_old;
        end
        if (state == st_max) job_q.m_new <= m_search;
        if (state == st_wait && res_out.req && !res_out.ack) o_out <= res_out.payload;
    end

    //////////////////////////////
    // row FSM
    //////////////////////////////
    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state        <= st_idle;
            o_ack        <= 1'b0;
            job_pv.req   <= 1'b0;
            job_hist.req <= 1'b0;
            res_out.ack  <= 1'b0;
        end else begin
            if (res_out.ack && !res_out.req) res_out.ack <= 1'b0;   // phase 4
            case (state)
                st_idle: begin
                    if (i_req) state <= st_max;
                end
                st_max: state <= st_dispatch;
                st_dispatch: begin
                    if (!job_pv.req) begin
                        job_pv.req   <= 1'b1;
                        job_hist.req <= 1'b1;
                    end else if (job_pv.ack && job_hist.ack) begin
                        job_pv.req   <= 1'b0;   // both units took the job
                        job_hist.req <= 1'b0;
                        state        <= st_wait;
                    end
                end
                st_wait: begin
                    if (res_out.req && !res_out.ack) begin
                        res_out.ack <= 1'b1;
                        state       <= st_reply;
                    end
                end
                st_reply: begin
                    if (!o_ack) begin
                        o_ack <= 1'b1;
                    end else if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_job_stable: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        $past(job_pv.req) && job_pv.req |-> $stable(job_pv.payload));

    a_ack_needs_req: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        $rose(o_ack) |-> i_req);

endmodule

/* hdl/prob_weight_unit.sv */
`timescale 1ns/1ps

module prob_weight_unit (
    input  logic         I_CLK,
    input  logic         I_ASYN_RSTN,
    req_ack_if.responder job,
    req_ack_if.initiator res
);
    import attn_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wgt,
        st_acc,
        st_res
    } state_t;

    state_t                   state;
    logic [$clog2(N_KEY)-1:0] key;    // key index of both passes
    logic                     take;
    logic [SCORE_W:0]         gap;
    row_job_t                 job_q;
    weight_t  [N_KEY-1:0]     wgt;
    sum_t                     l_new;
    acc_t     [D_VAL-1:0]     acc;

    assign take = (state == st_idle) && job.req && !job.ack && !res.ack;
    assign gap  = job_q.m_new - job_q.scores[key];   // never negative

    always_comb begin
        res.payload.l_pv = l_new;
        for (int c = 0; c < D_VAL; c++) begin
            res.payload.pv[c] = acc[c] >>> W_SHIFT;
        end
    end

    //////////////////////////////
    // weights, then w * v
    //////////////////////////////
    always_ff @(posedge I_CLK) begin
        if (take) begin
            job_q <= job.payload;
            l_new <= '0;
            acc   <= '0;
        end
        if (state == st_wgt) begin
            wgt[key] <= exp_weight(gap);
            l_new    <= l_new + exp_weight(gap);
        end
        if (state == st_acc) begin
            for (int c = 0; c < D_VAL; c++) begin
                acc[c] <= acc[c] + $signed({1'b0, wgt[key]}) * job_q.values[key][c];
            end
        end
    end

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state   <= st_idle;
            key     <= '0;
            job.ack <= 1'b0;
            res.req <= 1'b0;
        end else begin
            if (job.ack && !job.req) job.ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (take) begin
                        job.ack <= 1'b1;   // taken, not finished
                        key     <= '0;
                        state   <= st_wgt;
                    end
                end
                st_wgt: begin
                    key <= key + 1'b1;
                    if (key == N_KEY-1) state <= st_acc;
                end
                st_acc: begin
                    key <= key + 1'b1;
                    if (key == N_KEY-1) begin
                        res.req <= 1'b1;
                        state   <= st_res;
                    end
                end
                st_res: begin
                    if (res.ack) begin
                        res.req <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // a new job never lands on an unreturned result
    a_no_overlap: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        job.req |-> !res.req);

endmodule

/* hdl/history_rescale_unit.sv */
`timescale 1ns/1ps

module history_rescale_unit (
    input  logic         I_CLK,
    input  logic         I_ASYN_RSTN,
    req_ack_if.responder job,
    req_ack_if.initiator res
);
    import attn_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wgt,
        st_scale,
        st_res
    } state_t;

    state_t                        state;
    logic [$clog2(D_VAL)-1:0]      col;
    logic                          take;
    logic [SCORE_W:0]              rise;   // m_new - m_old
    weight_t                       wgt;
    sum_t                          l_old;
    acc_t [D_VAL-1:0]              o_old;
    logic signed [ACC_W+WGT_W:0]   o_prod;
    logic [SUM_W+WGT_W-1:0]        l_prod;
    hist_result_t                  res_q;

    assign take        = (state == st_idle) && job.req && !job.ack && !res.ack;
    assign o_prod      = o_old[col] * $signed({1'b0, wgt});
    assign l_prod      = l_old * wgt;
    assign res.payload = res_q;

    always_ff @(posedge I_CLK) begin
        if (take) begin
            rise        <= job.payload.m_new - job.payload.m_old;
            l_old       <= job.payload.l_old;
            o_old       <= job.payload.o_old;
            res_q.m_new <= job.payload.m_new;
        end
        if (state == st_wgt) wgt <= exp_weight(rise);
        if (state == st_scale) begin
            res_q.o_scaled[col] <= acc_t'(o_prod >>> W_SHIFT);   // one element per cycle
            if (col == 0) res_q.l_scaled <= sum_t'(l_prod >> W_SHIFT);
        end
    end

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state   <= st_idle;
            col     <= '0;
            job.ack <= 1'b0;
            res.req <= 1'b0;
        end else begin
            if (job.ack && !job.req) job.ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (take) begin
                        job.ack <= 1'b1;
                        col     <= '0;
                        state   <= st_wgt;
                    end
                end
                st_wgt: state <= st_scale;
                st_scale: begin
                    col <= col + 1'b1;
                    if (col == D_VAL-1) begin
                        res.req <= 1'b1;
                        state   <= st_res;
                    end
                end
                st_res: begin
                    if (res.ack) begin
                        res.req <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* hdl/row_merge.sv */
`timescale 1ns/1ps

module row_merge (
    input  logic         I_CLK,
    input  logic         I_ASYN_RSTN,
    req_ack_if.responder res_pv,
    req_ack_if.responder res_hist,
    req_ack_if.initiator res_out
);
    import attn_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_out,
        st_rel
    } state_t;

    state_t         state;
    logic           both;
    logic [SUM_W:0] l_wide;   // one carry bit for saturation
    row_out_t       out_q;

    assign both = res_pv.req && res_hist.req && !res_pv.ack && !res_hist.ack && !res_out.ack;
    assign l_wide = res_pv.payload.l_pv + res_hist.payload.l_scaled;
    assign res_out.payload = out_q;

    always_ff @(posedge I_CLK) begin
        if (state == st_idle && both) begin
            out_q.m_new <= res_hist.payload.m_new;
            out_q.l_new <= l_wide[SUM_W] ? '1 : l_wide[SUM_W-1:0];
            for (int c = 0; c < D_VAL; c++) begin
                out_q.o_new[c] <= res_hist.payload.o_scaled[c] + res_pv.payload.pv[c];
            end
        end
    end

    always_ff @(posedge I_CLK or negedge I_ASYN_RSTN) begin
        if (!I_ASYN_RSTN) begin
            state        <= st_idle;
            res_out.req  <= 1'b0;
            res_pv.ack   <= 1'b0;
            res_hist.ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (both) begin
                        res_out.req <= 1'b1;
                        state       <= st_out;
                    end
                end
                st_out: begin
                    if (res_out.ack) begin
                        res_out.req  <= 1'b0;
                        res_pv.ack   <= 1'b1;   // release both units only now
                        res_hist.ack <= 1'b1;
                        state        <= st_rel;
                    end
                end
                st_rel: begin
                    if (!res_pv.req) res_pv.ack <= 1'b0;
                    if (!res_hist.req) res_hist.ack <= 1'b0;
                    if (!res_pv.ack && !res_hist.ack) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_pv_stable: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        $past(res_pv.req) && res_pv.req |-> $stable(res_pv.payload));

    a_hist_stable: assert property (@(posedge I_CLK) disable iff (!I_ASYN_RSTN)
        $past(res_hist.req) && res_hist.req |-> $stable(res_hist.payload));

endmodule

/* hdl/attn_tile_top.sv */
`timescale 1ns/1ps

module attn_tile_top (
    input  logic                                                   I_CLK,
    input  logic                                                   I_ASYN_RSTN,
    input  logic                                                   i_req,
    output logic                                                   o_ack,
    input  attn_pkg::score_t [attn_pkg::N_KEY-1:0]                 i_scores,
    input  attn_pkg::val_t   [attn_pkg::N_KEY-1:0][attn_pkg::D_VAL-1:0] i_values,
    input  attn_pkg::score_t                                       i_m_old,
    input  attn_pkg::sum_t                                         i_l_old,
    input  attn_pkg::acc_t   [attn_pkg::D_VAL-1:0]                 i_o_old,
    output attn_pkg::score_t                                       o_m_new,
    output attn_pkg::sum_t                                         o_l_new,
    output attn_pkg::acc_t   [attn_pkg::D_VAL-1:0]                 o_o_new
);
    import attn_pkg::*;

    row_out_t out_row;   // held while o_ack is high

    //////////////////////////////
    // internal handshakes
    //////////////////////////////
    req_ack_if #(.payload_t(row_job_t))     job_pv   ();
    req_ack_if #(.payload_t(row_job_t))     job_hist ();
    req_ack_if #(.payload_t(pv_result_t))   res_pv   ();
    req_ack_if #(.payload_t(hist_result_t)) res_hist ();
    req_ack_if #(.payload_t(row_out_t))     res_out  ();

    attn_row_ctrl u_ctrl (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_req       (i_req),
        .o_ack       (o_ack),
        .i_scores    (i_scores),
        .i_values    (i_values),
        .i_m_old     (i_m_old),
        .i_l_old     (i_l_old),
        .i_o_old     (i_o_old),
        .o_out       (out_row),
        .job_pv      (job_pv),
        .job_hist    (job_hist),
        .res_out     (res_out)
    );

    prob_weight_unit u_pv (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .job         (job_pv),
        .res         (res_pv)
    );

    history_rescale_unit u_hist (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .job         (job_hist),
        .res         (res_hist)
    );

    row_merge u_merge (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .res_pv      (res_pv),
        .res_hist    (res_hist),
        .res_out     (res_out)
    );

    assign o_m_new = out_row.m_new;
    assign o_l_new = out_row.l_new;
    assign o_o_new = out_row.o_new;

endmodule

/* bench/tb_attn_ref.svh */
`ifndef TB_ATTN_REF_SVH
`define TB_ATTN_REF_SVH

// 2^-gap with W_SHIFT fraction bits, nothing left past GAP_MAX
function automatic int gap_weight(input int gap);
    int w;
    if (gap > GAP_MAX) w = 0;
    else w = 1 << (W_SHIFT - gap);
    return w;
endfunction

//////////////////////////////
// expected row update
//////////////////////////////
function automatic row_out_t attn_ref(input row_job_t job);
    row_out_t r;
    int       m;
    int       w_hist;
    int       w_new [N_KEY];
    longint   l_sum;
    longint   pv;
    longint   hist;
    m = $signed(job.m_old);
    for (int k = 0; k < N_KEY; k++) begin
        if ($signed(job.scores[k]) > m) m = $signed(job.scores[k]);
    end
    w_hist = gap_weight(m - $signed(job.m_old));   // rise of the maximum
    l_sum  = (longint'(job.l_old) * w_hist) >> W_SHIFT;
    for (int k = 0; k < N_KEY; k++) begin
        w_new[k] = gap_weight(m - $signed(job.scores[k]));
        l_sum    = l_sum + w_new[k];
    end
    r.m_new = score_t'(m);
    if (l_sum >= (longint'(1) << SUM_W)) r.l_new = '1;   // saturate
    else r.l_new = sum_t'(l_sum);
    for (int c = 0; c < D_VAL; c++) begin
        pv = 0;
        for (int k = 0; k < N_KEY; k++) begin
            pv = pv + longint'(w_new[k]) * $signed(job.values[k][c]);
        end
        pv   = pv >>> W_SHIFT;
        hist = ($signed(job.o_old[c]) * longint'(w_hist)) >>> W_SHIFT;
        r.o_new[c] = acc_t'(hist + pv);   // wraps like the 24 bit adder
    end
    return r;
endfunction

`endif

/* bench/tb_attn_tile.sv */
`timescale 1ns/1ps

module tb_attn_tile;
    import attn_pkg::*;

    localparam int RST_CYCLES     = 8;
    localparam int N_CHAIN        = 200;
    localparam int N_TESTS        = 4 + N_CHAIN;
    localparam int TIMEOUT_CYCLES = N_TESTS * 40 + RST_CYCLES;

    logic                        I_CLK;
    logic                        I_ASYN_RSTN;
    logic                        i_req;
    logic                        o_ack;
    score_t [N_KEY-1:0]          i_scores;
    val_t   [N_KEY-1:0][D_VAL-1:0] i_values;
    score_t                      i_m_old;
    sum_t                        i_l_old;
    acc_t   [D_VAL-1:0]          i_o_old;
    score_t                      o_m_new;
    sum_t                        o_l_new;
    acc_t   [D_VAL-1:0]          o_o_new;

    row_out_t exp_row;      // expected result of the request in flight
    int       n_sent = 0;
    int       n_acks = 0;
    int       cycles = 0;
    logic     ack_q  = 1'b0;

    `include "tb_attn_ref.svh"

    attn_tile_top DUT (
        .I_CLK       (I_CLK),
        .I_ASYN_RSTN (I_ASYN_RSTN),
        .i_req       (i_req),
        .o_ack       (o_ack),
        .i_scores    (i_scores),
        .i_values    (i_values),
        .i_m_old     (i_m_old),
        .i_l_old     (i_l_old),
        .i_o_old     (i_o_old),
        .o_m_new     (o_m_new),
        .o_l_new     (o_l_new),
        .o_o_new     (o_o_new)
    );

    always #50 I_CLK = ~I_CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_sum(input string name, input sum_t got, input sum_t exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic score_t clamp_score(input int x);
        if (x > 127) return 8'sd127;
        if (x < -128) return -8'sd128;
        return score_t'(x);
    endfunction

    task automatic build_job(output row_job_t job, input int m_old, input int l_old,
                             input int s [N_KEY], input int o [D_VAL], input int base);
        job       = '0;
        job.m_old = score_t'(m_old);
        job.l_old = sum_t'(l_old);
        for (int k = 0; k < N_KEY; k++) begin
            job.scores[k] = score_t'(s[k]);
            for (int c = 0; c < D_VAL; c++) begin
                job.values[k][c] = val_t'(base + 37 * k - 23 * c);   // spread over both indices
            end
        end
        for (int c = 0; c < D_VAL; c++) begin
            job.o_old[c] = acc_t'(o[c]);
        end
    endtask

    // one full four-phase cycle with a random hold before i_req falls
    task automatic run_tile(input row_job_t job);
        int hold;
        exp_row = attn_ref(job);
        hold    = $urandom_range(0, 6);
        @(posedge I_CLK);
        i_scores <= job.scores;
        i_values <= job.values;
        i_m_old  <= job.m_old;
        i_l_old  <= job.l_old;
        i_o_old  <= job.o_old;
        i_req    <= 1'b1;
        n_sent++;
        do @(posedge I_CLK); while (!o_ack);
        repeat (hold) @(posedge I_CLK);
        i_req <= 1'b0;
        do @(posedge I_CLK); while (o_ack);
    endtask

    //////////////////////////////
    // compare and timeout
    //////////////////////////////
    always @(negedge I_CLK) begin
        if (o_ack) begin
            if (n_sent == 0) begin
                abort_run("o_ack went high after reset before any request");
            end else begin
                if (!ack_q) n_acks++;   // outputs must also hold while o_ack stays high
                check_score("o_m_new", o_m_new, exp_row.m_new);
                check_sum("o_l_new", o_l_new, exp_row.l_new);
                for (int c = 0; c < D_VAL; c++) begin
                    check_acc($sformatf("o_o_new[%0d]", c), o_o_new[c], exp_row.o_new[c]);
                end
            end
        end
        ack_q = o_ack;
    end

    always @(posedge I_CLK) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the tests did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        row_job_t job;
        int       center;
        int       jitter;
        I_CLK       = 1'b0;
        I_ASYN_RSTN = 1'b0;
        i_req       = 1'b0;
        i_scores    = '0;
        i_values    = '0;
        i_m_old     = '0;
        i_l_old     = '0;
        i_o_old     = '0;
        void'($urandom(32'h6306_e53b));
        repeat (RST_CYCLES) @(posedge I_CLK);
        I_ASYN_RSTN <= 1'b1;
        repeat (4) @(posedge I_CLK);   // o_ack watched low here

        build_job(job, -128, 0, '{10, 8, 5, 3}, '{0, 0, 0, 0}, 17);   // first tile
        run_tile(job);
        build_job(job, 0, 300, '{2, 1, -3, 0}, '{1000, -2000, 300, -40}, -50);
        run_tile(job);
        build_job(job, 20, 500, '{19, 17, 15, 12}, '{-7000, 123, 4096, 0}, 90);
        run_tile(job);
        build_job(job, -100, 1000, '{50, 30, 45, 41}, '{80000, -80000, 5, -5}, 3);
        run_tile(job);

        // chained tiles, maximum drifts upward over the run
        for (int t = 0; t < N_CHAIN; t++) begin
            center    = -100 + t;
            job.m_old = exp_row.m_new;
            job.l_old = exp_row.l_new;
            job.o_old = exp_row.o_new;
            for (int k = 0; k < N_KEY; k++) begin
                jitter        = int'($urandom_range(0, 24)) - 12;
                job.scores[k] = clamp_score(center + jitter);
                for (int c = 0; c < D_VAL; c++) begin
                    job.values[k][c] = val_t'($urandom_range(0, 255));
                end
            end
            run_tile(job);
        end

        repeat (2) @(posedge I_CLK);
        if (n_acks != N_TESTS) begin
            abort_run($sformatf("only %0d of %0d requests got an o_ack", n_acks, N_TESTS));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+bench
hdl/attn_pkg.sv
hdl/req_ack_if.sv
hdl/attn_row_ctrl.sv
hdl/prob_weight_unit.sv
hdl/history_rescale_unit.sv
hdl/row_merge.sv
hdl/attn_tile_top.sv
bench/tb_attn_tile.sv

/* Bender.yml */
package:
  name: attn_tile

sources:
  - files:
      - hdl/attn_pkg.sv
      - hdl/req_ack_if.sv
      - hdl/attn_row_ctrl.sv
      - hdl/prob_weight_unit.sv
      - hdl/history_rescale_unit.sv
      - hdl/row_merge.sv
      - hdl/attn_tile_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_attn_tile.sv
